//--- bench/l2_cache_assertions.sv
`timescale 1ns/1ps

module l2_cache_assertions (
	input  logic             i_clock,
	input  logic             i_arst_n,
	input  l2_pkg::wb_req_t  i_cpu_req,
	input  l2_pkg::wb_rsp_t  i_cpu_rsp,
	input  l2_pkg::wb_req_t  i_mem_req,
	input  l2_pkg::wb_rsp_t  i_mem_rsp
);

	int unsigned fail_count = 0; // Read by the bench.

	//////////////////////////////
	// Ack pulses.
	//////////////////////////////

	cpu_ack_one_cycle: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_cpu_rsp.ack |=> !i_cpu_rsp.ack)
	else begin
		fail_count++;
		$error("Processor ack held longer than one cycle.");
	end

	mem_ack_one_cycle: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_mem_rsp.ack |=> !i_mem_rsp.ack)
	else begin
		fail_count++;
		$error("Memory ack held longer than one cycle.");
	end

	cpu_ack_in_cycle: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_cpu_rsp.ack |-> (i_cpu_req.cyc && i_cpu_req.stb))
	else begin
		fail_count++;
		$error("Processor ack outside a bus cycle.");
	end

	mem_ack_in_cycle: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_mem_rsp.ack |-> (i_mem_req.cyc && i_mem_req.stb))
	else begin
		fail_count++;
		$error("Memory ack outside a bus cycle.");
	end

	mem_stb_needs_cyc: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_mem_req.stb |-> i_mem_req.cyc)
	else begin
		fail_count++;
		$error("Memory stb high without cyc.");
	end

endmodule

bind l2_cache_top l2_cache_assertions u_assertions (
	.i_clock   (i_clock),
	.i_arst_n  (i_arst_n),
	.i_cpu_req (i_cpu_req),
	.i_cpu_rsp (o_cpu_rsp),
	.i_mem_req (o_mem_req),
	.i_mem_rsp (i_mem_rsp)
);

//--- bench/l2_cache_tb.sv
`timescale 1ns/1ps
`include "l2_consts.svh"

module l2_cache_tb;

	localparam int NUM_STEPS     = 18;
	localparam int PASS_STEPS    = 2;  // Issued before the cache is ready.
	localparam int RESET_AT      = 15; // First step after the second reset.
	localparam int INIT_CYCLES   = 1 << `L2_INDEX_BITS;
	localparam int HIT_LATENCY   = 2;
	localparam int ACK_TIMEOUT   = 64;
	localparam int READY_TIMEOUT = 200;

	typedef struct packed {
		logic                      we;
		logic [`L2_ADDR_BITS-1:0]  adr;
		logic [`L2_DATA_BITS-1:0]  dat;
		logic                      exp_hit;
	} step_t;

	logic             clock;
	logic             arst_n;
	l2_pkg::wb_req_t  cpu_req;
	l2_pkg::wb_rsp_t  cpu_rsp;
	l2_pkg::wb_req_t  mem_req;
	l2_pkg::wb_rsp_t  mem_rsp;
	logic             cache_ready;
	logic [31:0]      hits;
	logic [31:0]      misses;
	logic [31:0]      write_count;
	logic [31:0]      last_wr_adr;
	logic [31:0]      last_wr_dat;

	step_t                     steps [NUM_STEPS];
	logic [31:0]               shadow_mem [logic [31:0]];
	logic                      shadow_valid [INIT_CYCLES];
	logic [`L2_TAG_BITS-1:0]   shadow_tag [INIT_CYCLES];
	logic [31:0]               ref_hits;   // Expected hit count.
	logic [31:0]               ref_misses; // Expected miss count.

	int  errors;
	int  timeouts;
	bit  timed_out;
	int  cycle_count; // Edges since reset release.
	bit  ready_seen;
	int  ready_cycle;

	l2_cache_top i_dut (
		.i_clock       (clock),
		.i_arst_n      (arst_n),
		.i_cpu_req     (cpu_req),
		.o_cpu_rsp     (cpu_rsp),
		.o_mem_req     (mem_req),
		.i_mem_rsp     (mem_rsp),
		.o_cache_ready (cache_ready),
		.o_hits        (hits),
		.o_misses      (misses)
	);

	wb_mem_model #(.SEED(3), .MAX_DELAY(3)) u_mem (
		.i_clock       (clock),
		.i_req         (mem_req),
		.o_rsp         (mem_rsp),
		.o_write_count (write_count),
		.o_last_wr_adr (last_wr_adr),
		.o_last_wr_dat (last_wr_dat)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock or negedge arst_n) begin
		if (!arst_n) cycle_count <= 0;
		else cycle_count <= cycle_count + 1;
	end

	// Edge count at which the cache first reports ready.
	always @(negedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ready_seen <= 1'b0;
		end else if (cache_ready && !ready_seen) begin
			ready_seen <= 1'b1;
			ready_cycle <= cycle_count;
		end
	end

	//////////////////////////////
	// Helpers.
	//////////////////////////////

	function automatic logic [31:0] initial_word(input logic [31:0] adr);
		return {adr[15:0], adr[31:16]} ^ 32'h5A3C_96E1;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] adr);
		if (shadow_mem.exists(adr)) return shadow_mem[adr];
		return initial_word(adr);
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic load_table();
		steps[0]  = '{1'b0, 32'h0000_0040, 32'h0, 1'b0};
		steps[1]  = '{1'b1, 32'h0000_0044, 32'h1111_2222, 1'b0};
		steps[2]  = '{1'b0, 32'h0000_0040, 32'h0, 1'b0};
		steps[3]  = '{1'b0, 32'h0000_0040, 32'h0, 1'b1};
		steps[4]  = '{1'b0, 32'h0000_0044, 32'h0, 1'b0};
		steps[5]  = '{1'b0, 32'h0000_0044, 32'h0, 1'b1};
		steps[6]  = '{1'b1, 32'h0000_1080, 32'hDEAD_BEEF, 1'b0};
		steps[7]  = '{1'b0, 32'h0000_1080, 32'h0, 1'b1};
		steps[8]  = '{1'b0, 32'h0000_0100, 32'h0, 1'b0}; // A.
		steps[9]  = '{1'b0, 32'h0000_0200, 32'h0, 1'b0}; // B with the same index.
		steps[10] = '{1'b0, 32'h0000_0100, 32'h0, 1'b0};
		steps[11] = '{1'b0, 32'h0000_0100, 32'h0, 1'b1};
		steps[12] = '{1'b1, 32'h0000_0300, 32'hCAFE_0001, 1'b0};
		steps[13] = '{1'b0, 32'h0000_0100, 32'h0, 1'b0};
		steps[14] = '{1'b0, 32'h0000_0300, 32'h0, 1'b0};
		steps[15] = '{1'b0, 32'h0000_0040, 32'h0, 1'b0};
		steps[16] = '{1'b0, 32'h0000_1080, 32'h0, 1'b0};
		steps[17] = '{1'b0, 32'h0000_1080, 32'h0, 1'b1};
	endtask

	task automatic clear_shadow_tags();
		for (int i = 0; i < INIT_CYCLES; i++) begin
			shadow_valid[i] = 1'b0;
			shadow_tag[i] = '0;
		end
	endtask

	task automatic apply_reset();
		arst_n <= 1'b0;
		ref_hits = '0;
		ref_misses = '0;
		repeat (3) @(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		if (hits != 32'd0 || misses != 32'd0) begin
			report_error($sformatf("counters %0d/%0d after reset", hits, misses));
		end
		if (cache_ready) report_error("cache ready right after reset");
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!ready_seen && cycles < READY_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!ready_seen) begin
			timed_out = 1'b1;
			timeouts++;
			$display("Timed out at %0t waiting for the cache to become ready", $time);
		end else if (ready_cycle != INIT_CYCLES) begin
			report_error($sformatf("ready after %0d cycles, expected %0d",
				ready_cycle, INIT_CYCLES));
		end
	endtask

	// One Wishbone classic cycle on the processor port.
	task automatic do_access(input step_t s, output logic [31:0] data, output int latency);
		int cycles;
		@(posedge clock);
		cpu_req <= '{cyc: 1'b1, stb: 1'b1, we: s.we, adr: s.adr, dat: s.dat};
		cycles = 0;
		@(negedge clock);
		while (!cpu_rsp.ack && cycles < ACK_TIMEOUT) begin
			@(posedge clock);
			cycles++;
			@(negedge clock);
		end
		data = cpu_rsp.dat;
		latency = cycles - 1; // Counted from the edge that samples stb.
		if (!cpu_rsp.ack) begin
			timed_out = 1'b1;
			timeouts++;
			$display("Timed out at %0t waiting for the processor ack at address %h",
				$time, s.adr);
		end
		@(posedge clock);
		cpu_req <= '0;
	endtask

	//////////////////////////////
	// One table step.
	//////////////////////////////

	task automatic run_step(input int n, input bit cached);
		step_t                     s;
		logic [31:0]               data;
		int                        latency;
		logic [`L2_INDEX_BITS-1:0] idx;
		logic [`L2_TAG_BITS-1:0]   tag;
		logic                      model_hit;
		logic [31:0]               writes_before;

		s = steps[n];
		idx = s.adr[`L2_INDEX_BITS+1:2];
		tag = s.adr[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];
		model_hit = cached && !s.we && shadow_valid[idx] && (shadow_tag[idx] == tag);
		if (model_hit != (cached && !s.we && s.exp_hit)) begin
			report_error($sformatf("step %0d hit flag disagrees with the reference model", n));
		end

		writes_before = write_count;
		if (cached && !s.we) begin
			if (s.exp_hit) ref_hits = ref_hits + 32'd1;
			else ref_misses = ref_misses + 32'd1;
		end

		do_access(s, data, latency);
		if (timed_out) return;

		if (!s.we && data != expected_word(s.adr)) begin
			report_error($sformatf("step %0d read %h from %h, expected %h",
				n, data, s.adr, expected_word(s.adr)));
		end
		if (hits != ref_hits || misses != ref_misses) begin
			report_error($sformatf("step %0d counters %0d/%0d, expected %0d/%0d",
				n, hits, misses, ref_hits, ref_misses));
		end
		if (cached && !s.we && s.exp_hit && latency != HIT_LATENCY) begin
			report_error($sformatf("step %0d hit ack after %0d cycles", n, latency));
		end
		if (!cached && ready_seen) report_error($sformatf("step %0d was not a pass-through", n));

		if (s.we) begin
			if (write_count != writes_before + 32'd1 || last_wr_adr != s.adr
				|| last_wr_dat != s.dat) begin
				report_error($sformatf("step %0d write of %h to %h missing in the log",
					n, s.dat, s.adr));
			end
			shadow_mem[s.adr] = s.dat;
		end else if (write_count != writes_before) begin
			report_error($sformatf("step %0d read caused a memory write", n));
		end

		if (cached && !model_hit) begin
			shadow_valid[idx] = 1'b1; // Fill or write-allocate.
			shadow_tag[idx] = tag;
		end
	endtask

	task automatic run_tests();
		apply_reset();
		for (int n = 0; n < PASS_STEPS; n++) begin
			run_step(n, 1'b0);
			if (timed_out) return;
		end
		wait_ready();
		if (timed_out) return;
		for (int n = PASS_STEPS; n < RESET_AT; n++) begin
			run_step(n, 1'b1);
			if (timed_out) return;
		end

		@(posedge clock);
		apply_reset();
		clear_shadow_tags();
		wait_ready();
		if (timed_out) return;
		for (int n = RESET_AT; n < NUM_STEPS; n++) begin
			run_step(n, 1'b1);
			if (timed_out) return;
		end
	endtask

	initial begin
		int assert_fails;
		arst_n = 1'b0;
		cpu_req = '0;
		errors = 0;
		timeouts = 0;
		timed_out = 1'b0;
		ref_hits = '0;
		ref_misses = '0;
		load_table();
		clear_shadow_tags();

		run_tests();

		assert_fails = int'(i_dut.u_assertions.fail_count);
		$display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, assert_fails);
		if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- bench/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model #(
	parameter int unsigned SEED      = 1,
	parameter int unsigned MAX_DELAY = 3
) (
	input  logic             i_clock,

	input  l2_pkg::wb_req_t  i_req,
	output l2_pkg::wb_rsp_t  o_rsp,

	// Write log.
	output logic [31:0]      o_write_count,
	output logic [31:0]      o_last_wr_adr,
	output logic [31:0]      o_last_wr_dat
);

	logic [31:0]  words [logic [31:0]]; // Words written so far.
	logic         busy;
	int unsigned  delay;

	// Contents of a word that was never written.
	function automatic logic [31:0] fill_word(input logic [31:0] adr);
		return {adr[15:0], adr[31:16]} ^ 32'h5A3C_96E1;
	endfunction

	//////////////////////////////
	// Slave response.
	//////////////////////////////

	initial begin
		o_rsp = '0;
		o_write_count = '0;
		o_last_wr_adr = '0;
		o_last_wr_dat = '0;
		busy = 1'b0;
		delay = 0;
		void'($urandom(SEED));
		forever begin
			@(posedge i_clock);
			if (o_rsp.ack) begin
				o_rsp.ack <= 1'b0; // Master drops cyc on this edge.
				busy <= 1'b0;
			end else if (i_req.cyc && i_req.stb) begin
				if (!busy) begin
					busy <= 1'b1;
					delay <= $urandom_range(MAX_DELAY, 0);
				end else if (delay == 0) begin
					o_rsp.ack <= 1'b1;
					if (i_req.we) begin
						words[i_req.adr] = i_req.dat;
						o_write_count <= o_write_count + 32'd1;
						o_last_wr_adr <= i_req.adr;
						o_last_wr_dat <= i_req.dat;
					end else if (words.exists(i_req.adr)) begin
						o_rsp.dat <= words[i_req.adr];
					end else begin
						o_rsp.dat <= fill_word(i_req.adr);
					end
				end else begin
					delay <= delay - 1;
				end
			end
		end
	end

endmodule

//--- include/l2_consts.svh
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

//////////////////////////////
// Bus widths.
//////////////////////////////

`define L2_ADDR_BITS 32  // Byte address.
`define L2_DATA_BITS 32  // One word per access.

//////////////////////////////
// Cache geometry.
//////////////////////////////

// 64 entries indexed by address bits 7 to 2.
`define L2_INDEX_BITS 6

// Whatever is left above the index and the byte offset.
`define L2_TAG_BITS (`L2_ADDR_BITS - `L2_INDEX_BITS - 2)

`endif

//--- project.f
+incdir+include
src/l2_pkg.sv
src/clear_ram.sv
src/l2_cache_ctrl.sv
src/l2_cache_top.sv
bench/wb_mem_model.sv
bench/l2_cache_assertions.sv
bench/l2_cache_tb.sv

//--- run.sh
#!/bin/sh
# Builds the cache testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module l2_cache_tb \
	-f project.f \
	-o l2_cache_sim

# Assertion errors are counted by the bench instead of stopping the run.
./obj_dir/l2_cache_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Everything OK" sim.log; then
	exit 0
fi
exit 1

//--- src/clear_ram.sv
`timescale 1ns/1ps

module clear_ram #(
	parameter type T_PAYLOAD = logic [31:0],
	parameter int  DEPTH_BITS = 6
) (
	input  logic                   i_clock,
	input  logic                   i_arst_n,

	input  logic                   i_we,
	input  logic [DEPTH_BITS-1:0]  i_addr,
	input  T_PAYLOAD               i_wdata,
	output T_PAYLOAD               o_rdata,

	output logic                   o_initialized
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	T_PAYLOAD mem [DEPTH];

	logic [DEPTH_BITS-1:0] clr_addr; // Next address to clear.
	logic                  initialized;

	//////////////////////////////
	// Clearing sweep.
	//////////////////////////////

	// One address per cycle from the first edge after reset.
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			clr_addr <= '0;
			initialized <= 1'b0;
		end else if (!initialized) begin
			clr_addr <= clr_addr + 1'b1;
			if (&clr_addr) begin
				initialized <= 1'b1; // Last address written this cycle.
			end
		end
	end

	assign o_initialized = initialized;

	//////////////////////////////
	// Storage.
	//////////////////////////////

	// The sweep owns the write port until it is done.
	always_ff @(posedge i_clock) begin
		if (!initialized) begin
			mem[clr_addr] <= '0;
		end else if (i_we) begin
			mem[i_addr] <= i_wdata;
		end
	end

	// Registered read returns old data on a write to the same address.
	always_ff @(posedge i_clock) begin
		o_rdata <= mem[i_addr];
	end

endmodule

//--- src/l2_cache_ctrl.sv
`timescale 1ns/1ps
`include "l2_consts.svh"

module l2_cache_ctrl (
	input  logic                       i_clock,
	input  logic                       i_arst_n,

	// Processor port, Wishbone slave.
	input  l2_pkg::wb_req_t            i_cpu_req,
	output l2_pkg::wb_rsp_t            o_cpu_rsp,

	// Memory port, Wishbone master.
	output l2_pkg::wb_req_t            o_mem_req,
	input  l2_pkg::wb_rsp_t            i_mem_rsp,

	// Cache RAM.
	output logic                       o_ram_we,
	output logic [`L2_INDEX_BITS-1:0]  o_ram_addr,
	output l2_pkg::l2_entry_t          o_ram_wdata,
	input  l2_pkg::l2_entry_t          i_ram_rdata,
	input  logic                       i_ram_initialized,

	output logic [31:0]                o_hits,
	output logic [31:0]                o_misses
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_FILL,
		ST_WRITE,
		ST_PASS
	} state_t;

	state_t state;
	logic   cmp_phase; // Set in the second lookup cycle when RAM data is valid.

	logic                      cpu_ack;
	logic [`L2_DATA_BITS-1:0]  cpu_dat;

	logic                      mem_cyc;
	logic                      mem_we;
	logic [`L2_ADDR_BITS-1:0]  mem_adr;
	logic [`L2_DATA_BITS-1:0]  mem_dat;

	logic                      ram_we;
	logic [`L2_INDEX_BITS-1:0] ram_addr;
	l2_pkg::l2_entry_t         ram_wdata;

	logic [`L2_ADDR_BITS-1:0]  req_adr; // Latched processor address.
	logic [31:0]               hits;
	logic [31:0]               misses;

	logic                      take;
	logic                      tag_hit;

	function automatic logic [`L2_INDEX_BITS-1:0] index_of(input logic [`L2_ADDR_BITS-1:0] adr);
		return adr[`L2_INDEX_BITS+1:2];
	endfunction

	function automatic logic [`L2_TAG_BITS-1:0] tag_of(input logic [`L2_ADDR_BITS-1:0] adr);
		return adr[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];
	endfunction

	// No new request while the previous ack is still out.
	assign take = (state == ST_IDLE) && i_cpu_req.cyc && i_cpu_req.stb && !cpu_ack;

	assign tag_hit = i_ram_rdata.valid && (i_ram_rdata.tag == tag_of(req_adr));

	//////////////////////////////
	// Control.
	//////////////////////////////

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			cmp_phase <= 1'b0;
			cpu_ack <= 1'b0;
			mem_cyc <= 1'b0;
			ram_we <= 1'b0;
			hits <= '0;
			misses <= '0;
		end else begin
			cpu_ack <= 1'b0;
			ram_we <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (take) begin
						if (!i_ram_initialized) begin
							mem_cyc <= 1'b1; // Straight to memory.
							state <= ST_PASS;
						end else if (i_cpu_req.we) begin
							mem_cyc <= 1'b1;
							ram_we <= 1'b1;  // Entry and memory together.
							state <= ST_WRITE;
						end else begin
							cmp_phase <= 1'b0;
							state <= ST_LOOKUP;
						end
					end
				end

				ST_LOOKUP: begin
					if (!cmp_phase) begin
						cmp_phase <= 1'b1;
					end else if (tag_hit) begin
						cpu_ack <= 1'b1;
						hits <= hits + 1'b1;
						state <= ST_IDLE;
					end else begin
						mem_cyc <= 1'b1;
						misses <= misses + 1'b1;
						state <= ST_FILL;
					end
				end

				ST_FILL: begin
					if (i_mem_rsp.ack) begin
						mem_cyc <= 1'b0;
						ram_we <= 1'b1; // Fill lands with the processor ack.
						cpu_ack <= 1'b1;
						state <= ST_IDLE;
					end
				end

				ST_WRITE, ST_PASS: begin
					if (i_mem_rsp.ack) begin
						mem_cyc <= 1'b0;
						cpu_ack <= 1'b1;
						state <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Addresses and data.
	//////////////////////////////

	always_ff @(posedge i_clock) begin
		case (state)
			ST_IDLE: begin
				if (take) begin
					req_adr <= i_cpu_req.adr;
					mem_adr <= i_cpu_req.adr;
					mem_we <= i_cpu_req.we;
					mem_dat <= i_cpu_req.dat;
					ram_addr <= index_of(i_cpu_req.adr);
					ram_wdata <= '{valid: 1'b1, tag: tag_of(i_cpu_req.adr),
						data: i_cpu_req.dat};
				end
			end

			ST_LOOKUP: cpu_dat <= i_ram_rdata.data; // Only used on a hit.

			ST_FILL: begin
				if (i_mem_rsp.ack) begin
					cpu_dat <= i_mem_rsp.dat;
					ram_wdata <= '{valid: 1'b1, tag: tag_of(req_adr), data: i_mem_rsp.dat};
				end
			end

			ST_PASS: begin
				if (i_mem_rsp.ack) begin
					cpu_dat <= i_mem_rsp.dat;
				end
			end

			default: ;
		endcase
	end

	assign o_cpu_rsp = '{ack: cpu_ack, dat: cpu_dat};

	// Classic single cycles keep stb equal to cyc.
	assign o_mem_req = '{cyc: mem_cyc, stb: mem_cyc, we: mem_we, adr: mem_adr, dat: mem_dat};

	assign o_ram_we = ram_we;
	assign o_ram_addr = ram_addr;
	assign o_ram_wdata = ram_wdata;

	assign o_hits = hits;
	assign o_misses = misses;

endmodule

//--- src/l2_cache_top.sv
`timescale 1ns/1ps
`include "l2_consts.svh"

module l2_cache_top (
	input  logic             i_clock,
	input  logic             i_arst_n,

	input  l2_pkg::wb_req_t  i_cpu_req,
	output l2_pkg::wb_rsp_t  o_cpu_rsp,

	output l2_pkg::wb_req_t  o_mem_req,
	input  l2_pkg::wb_rsp_t  i_mem_rsp,

	output logic             o_cache_ready,
	output logic [31:0]      o_hits,
	output logic [31:0]      o_misses
);

	logic                       ram_we;
	logic [`L2_INDEX_BITS-1:0]  ram_addr;
	l2_pkg::l2_entry_t          ram_wdata;
	l2_pkg::l2_entry_t          ram_rdata;
	logic                       ram_initialized;

	l2_cache_ctrl u_ctrl (
		.i_clock           (i_clock),
		.i_arst_n          (i_arst_n),
		.i_cpu_req         (i_cpu_req),
		.o_cpu_rsp         (o_cpu_rsp),
		.o_mem_req         (o_mem_req),
		.i_mem_rsp         (i_mem_rsp),
		.o_ram_we          (ram_we),
		.o_ram_addr        (ram_addr),
		.o_ram_wdata       (ram_wdata),
		.i_ram_rdata       (ram_rdata),
		.i_ram_initialized (ram_initialized),
		.o_hits            (o_hits),
		.o_misses          (o_misses)
	);

	// One entry per index.
	clear_ram #(
		.T_PAYLOAD  (l2_pkg::l2_entry_t),
		.DEPTH_BITS (`L2_INDEX_BITS)
	) u_ram (
		.i_clock       (i_clock),
		.i_arst_n      (i_arst_n),
		.i_we          (ram_we),
		.i_addr        (ram_addr),
		.i_wdata       (ram_wdata),
		.o_rdata       (ram_rdata),
		.o_initialized (ram_initialized)
	);

	assign o_cache_ready = ram_initialized;

endmodule

//--- src/l2_pkg.sv
`include "l2_consts.svh"

package l2_pkg;

	//////////////////////////////
	// Wishbone classic.
	//////////////////////////////

	// Master to slave.
	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic                      we;  // High for a write.
		logic [`L2_ADDR_BITS-1:0]  adr;
		logic [`L2_DATA_BITS-1:0]  dat; // Write data.
	} wb_req_t;

	// Slave to master.
	typedef struct packed {
		logic                      ack; // One cycle per access.
		logic [`L2_DATA_BITS-1:0]  dat; // Read data valid with ack.
	} wb_rsp_t;

	//////////////////////////////
	// Cache storage.
	//////////////////////////////

	// All zero is the invalid entry.
	typedef struct packed {
		logic                      valid;
		logic [`L2_TAG_BITS-1:0]   tag;
		logic [`L2_DATA_BITS-1:0]  data;
	} l2_entry_t;

endpackage
